// File: rtl/lsu_pkg.sv
/* Shared types for the load/store unit. Address bit 31 selects the peripheral bus,
   so the local memory sees only the lower half of the address space */
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  id_t;
    typedef logic [3:0]  be_t;
    typedef logic [2:0]  fn3_t;

    // RV32 load/store width codes
    localparam fn3_t FN3_B  = 3'b000;
    localparam fn3_t FN3_H  = 3'b001;
    localparam fn3_t FN3_W  = 3'b010;
    localparam fn3_t FN3_BU = 3'b100;
    localparam fn3_t FN3_HU = 3'b101;

    // Standard mcause values
    typedef enum logic [4:0] {
        EXC_LOAD_MISALIGNED  = 5'd4,
        EXC_STORE_MISALIGNED = 5'd6
    } exc_code_t;

    localparam int PBUS_SELECT_BIT = 31;

    typedef struct packed {
        word_t      rs1;
        logic [11:0] offset;
        word_t      rs2;
        fn3_t       fn3;
        logic       load;
        logic       store;
        id_t        id;
    } ls_request_t;

    // Store data is already placed on its byte lanes
    typedef struct packed {
        word_t addr;
        be_t   be;
        word_t data;
        logic  re;
        logic  we;
    } sub_request_t;

    typedef struct packed {
        fn3_t       fn3;
        logic [1:0] byte_addr;
        id_t        id;
        logic       unit;       // 0 local, 1 peripheral
    } load_attr_t;

endpackage

`default_nettype wire

// File: rtl/ls_issue.sv
/* Issue stage. Misaligned requests are accepted but reach no sub-unit, and
   the first exception blocks further issue until it is acknowledged */
`timescale 1ns/1ps
`default_nettype none

module ls_issue #(
    parameter int ATTR_DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  lsu_pkg::ls_request_t issue_req,
    input  logic                 issue_new_request,
    output logic                 issue_ready,
    input  logic                 local_ready,
    input  logic                 pbus_ready,
    input  logic                 attr_full,
    input  logic                 attr_empty,
    input  logic                 exception_ack,
    output logic                 exception_valid,
    output lsu_pkg::exc_code_t   exception_code,
    output lsu_pkg::word_t       exception_tval,
    output lsu_pkg::id_t         exception_id,
    output lsu_pkg::sub_request_t sub_req,
    output logic                 local_request,
    output logic                 pbus_request,
    output logic                 load_push,
    output lsu_pkg::load_attr_t  push_attr,
    output logic                 idle
);
    import lsu_pkg::*;

    // A single-entry FIFO never has two loads in flight
    localparam bit SWITCH_CHECK = (ATTR_DEPTH > 1);

    word_t addr;
    be_t   be;
    word_t store_data;
    logic  misaligned;
    logic  sel_pbus;
    logic  unit_ready;
    logic  accept;
    logic  new_exception;
    logic  last_unit;
    logic  unit_switch;
    logic  switch_in_progress;
    logic  switch_hold;

    ////////////////////
    // Address and lanes
    assign addr = issue_req.rs1 + {{20{issue_req.offset[11]}}, issue_req.offset};

    always_comb begin
        case (issue_req.fn3)
            FN3_H, FN3_HU: misaligned = addr[0];
            FN3_W:         misaligned = |addr[1:0];
            default:       misaligned = 1'b0;
        endcase
    end

    always_comb begin
        be = '0;
        case (issue_req.fn3[1:0])
            FN3_B[1:0]: be[addr[1:0]] = 1'b1;
            FN3_H[1:0]: be = addr[1] ? 4'b1100 : 4'b0011;
            default:    be = '1;
        endcase
    end

    // Replicate narrow store data over all lanes
    always_comb begin
        case (issue_req.fn3[1:0])
            FN3_B[1:0]: store_data = {4{issue_req.rs2[7:0]}};
            FN3_H[1:0]: store_data = {2{issue_req.rs2[15:0]}};
            default:    store_data = issue_req.rs2;
        endcase
    end

    ////////////////////
    // Unit select and switch hold
    assign sel_pbus = addr[PBUS_SELECT_BIT];
    assign unit_ready = sel_pbus ? pbus_ready : local_ready;

    // New load to other unit waits for outstanding loads to drain
    assign unit_switch = SWITCH_CHECK & issue_req.load & (sel_pbus != last_unit) & ~attr_empty;
    assign switch_hold = unit_switch | switch_in_progress;

    assign issue_ready = unit_ready & ~attr_full & ~exception_valid & ~switch_hold;
    assign accept = issue_new_request & issue_ready;
    assign new_exception = accept & misaligned;

    assign local_request = accept & ~misaligned & ~sel_pbus;
    assign pbus_request = accept & ~misaligned & sel_pbus;
    assign load_push = accept & ~misaligned & issue_req.load;

    assign sub_req = '{addr: addr, be: be, data: store_data,
                       re: issue_req.load, we: issue_req.store};
    assign push_attr = '{fn3: issue_req.fn3, byte_addr: addr[1:0],
                         id: issue_req.id, unit: sel_pbus};

    assign idle = attr_empty & local_ready & pbus_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_unit <= 1'b0;
            switch_in_progress <= 1'b0;
            exception_valid <= 1'b0;
        end else begin
            if (load_push)
                last_unit <= sel_pbus;
            switch_in_progress <= (switch_in_progress | unit_switch) & ~attr_empty;
            exception_valid <= (exception_valid & ~exception_ack) | new_exception;
        end
    end

    ////////////////////
    // Exception details
    always_ff @(posedge clk) begin
        if (new_exception) begin
            exception_code <= issue_req.store ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
            exception_tval <= addr;
            exception_id <= issue_req.id;
        end
    end

endmodule

`default_nettype wire

// File: rtl/local_mem_sub_unit.sv
/* Local data memory. Depth must be a power of two, and the address wraps
   modulo the depth */
`timescale 1ns/1ps
`default_nettype none

module local_mem_sub_unit #(
    parameter int LOCAL_MEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  lsu_pkg::sub_request_t sub_req,
    input  logic                  request,
    output logic                  ready,
    output logic                  data_valid,
    output lsu_pkg::word_t        read_data
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(LOCAL_MEM_WORDS);

    word_t            mem [LOCAL_MEM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = sub_req.addr[IDX_W+1:2];

    // Single-cycle access that never stalls
    assign ready = 1'b1;

    always_ff @(posedge clk) begin
        if (request & sub_req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (sub_req.be[i])
                    mem[idx][i*8 +: 8] <= sub_req.data[i*8 +: 8];
            end
        end
        if (request & sub_req.re)
            read_data <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (rst)
            data_valid <= 1'b0;
        else
            data_valid <= request & sub_req.re;
    end

endmodule

`default_nettype wire

// File: rtl/pbus_sub_unit.sv
/* Peripheral bus master, one access at a time. The device must ack no
   earlier than the cycle after the strobe */
`timescale 1ns/1ps
`default_nettype none

module pbus_sub_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  lsu_pkg::sub_request_t sub_req,
    input  logic                  request,
    output logic                  ready,
    output logic                  data_valid,
    output lsu_pkg::word_t        read_data,
    output logic                  pbus_req,
    output logic                  pbus_we,
    output lsu_pkg::word_t        pbus_addr,
    output lsu_pkg::be_t          pbus_be,
    output lsu_pkg::word_t        pbus_wdata,
    input  logic                  pbus_ack,
    input  lsu_pkg::word_t        pbus_rdata
);
    import lsu_pkg::*;

    typedef enum logic {
        idle,
        wait_ack
    } state_t;

    state_t       state;
    sub_request_t req_q;

    assign ready = (state == idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            pbus_req <= 1'b0;
        end else begin
            // Strobe only in the first cycle of the access
            pbus_req <= request & ready;
            case (state)
                idle:     if (request) state <= wait_ack;
                wait_ack: if (pbus_ack) state <= idle;
                default:  state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (request & ready)
            req_q <= sub_req;
    end

    assign pbus_addr = req_q.addr;
    assign pbus_we = req_q.we;
    assign pbus_be = req_q.be;
    assign pbus_wdata = req_q.data;

    // Stores finish silently on ack
    assign data_valid = (state == wait_ack) & pbus_ack & req_q.re;
    assign read_data = pbus_rdata;

endmodule

`default_nettype wire

// File: rtl/load_writeback.sv
/* Load result path. Sub-units must return loads in issue order, which the
   issue stage guarantees by holding unit switches */
`timescale 1ns/1ps
`default_nettype none

module load_writeback #(
    parameter int ATTR_DEPTH = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_push,
    input  lsu_pkg::load_attr_t push_attr,
    output logic                attr_full,
    output logic                attr_empty,
    input  logic                local_valid,
    input  logic                pbus_valid,
    input  lsu_pkg::word_t      local_data,
    input  lsu_pkg::word_t      pbus_data,
    output logic                wb_done,
    output lsu_pkg::id_t        wb_id,
    output lsu_pkg::word_t      wb_rd
);
    import lsu_pkg::*;

    localparam int PTR_W = (ATTR_DEPTH > 1) ? $clog2(ATTR_DEPTH) : 1;
    localparam int CNT_W = $clog2(ATTR_DEPTH + 1);

    load_attr_t       attr_q [ATTR_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    load_attr_t       head;
    word_t            unit_data;
    logic [7:0]       sel_byte;
    logic [15:0]      sel_half;
    logic             is_signed;

    ////////////////////
    // Attributes FIFO
    assign pop = local_valid | pbus_valid;
    assign head = attr_q[rd_ptr];
    assign attr_full = (count == CNT_W'(ATTR_DEPTH));
    assign attr_empty = (count == '0);

    always_ff @(posedge clk) begin
        if (load_push)
            attr_q[wr_ptr] <= push_attr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (load_push)
                wr_ptr <= (wr_ptr == PTR_W'(ATTR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(ATTR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(load_push) - CNT_W'(pop);
        end
    end

    ////////////////////
    // Result alignment
    assign unit_data = head.unit ? pbus_data : local_data;
    assign sel_byte = unit_data[head.byte_addr*8 +: 8];
    assign sel_half = head.byte_addr[1] ? unit_data[31:16] : unit_data[15:0];
    assign is_signed = ~head.fn3[2];

    always_comb begin
        case (head.fn3[1:0])
            FN3_B[1:0]: wb_rd = {{24{is_signed & sel_byte[7]}}, sel_byte};
            FN3_H[1:0]: wb_rd = {{16{is_signed & sel_half[15]}}, sel_half};
            default:    wb_rd = unit_data;
        endcase
    end

    assign wb_done = pop;
    assign wb_id = head.id;

endmodule

`default_nettype wire

// File: rtl/load_store_unit.sv
/* Load/store unit top. Bit 31 clear maps to local memory, set maps to the
   peripheral bus, and misaligned accesses are reported only as exceptions */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit #(
    parameter int LOCAL_MEM_WORDS = 256,
    parameter int ATTR_DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  lsu_pkg::ls_request_t issue_req,
    input  logic                 issue_new_request,
    output logic                 issue_ready,
    input  logic                 exception_ack,
    output logic                 exception_valid,
    output lsu_pkg::exc_code_t   exception_code,
    output lsu_pkg::word_t       exception_tval,
    output lsu_pkg::id_t         exception_id,
    output logic                 pbus_req,
    output logic                 pbus_we,
    output lsu_pkg::word_t       pbus_addr,
    output lsu_pkg::be_t         pbus_be,
    output lsu_pkg::word_t       pbus_wdata,
    input  logic                 pbus_ack,
    input  lsu_pkg::word_t       pbus_rdata,
    output logic                 wb_done,
    output lsu_pkg::id_t         wb_id,
    output lsu_pkg::word_t       wb_rd,
    output logic                 idle
);
    import lsu_pkg::*;

    sub_request_t sub_req;
    load_attr_t   push_attr;
    logic         local_request;
    logic         pbus_request;
    logic         local_ready;
    logic         pbus_ready;
    logic         local_valid;
    logic         pbus_valid;
    word_t        local_data;
    word_t        pbus_data;
    logic         load_push;
    logic         attr_full;
    logic         attr_empty;

    ls_issue #(
        .ATTR_DEPTH(ATTR_DEPTH)
    ) i_ls_issue (
        .clk, .rst, .issue_req, .issue_new_request, .issue_ready,
        .local_ready, .pbus_ready, .attr_full, .attr_empty,
        .exception_ack, .exception_valid, .exception_code, .exception_tval, .exception_id,
        .sub_req, .local_request, .pbus_request, .load_push, .push_attr, .idle
    );

    local_mem_sub_unit #(
        .LOCAL_MEM_WORDS(LOCAL_MEM_WORDS)
    ) i_local_mem_sub_unit (
        .clk, .rst, .sub_req,
        .request(local_request), .ready(local_ready),
        .data_valid(local_valid), .read_data(local_data)
    );

    pbus_sub_unit i_pbus_sub_unit (
        .clk, .rst, .sub_req,
        .request(pbus_request), .ready(pbus_ready),
        .data_valid(pbus_valid), .read_data(pbus_data),
        .pbus_req, .pbus_we, .pbus_addr, .pbus_be, .pbus_wdata, .pbus_ack, .pbus_rdata
    );

    load_writeback #(
        .ATTR_DEPTH(ATTR_DEPTH)
    ) i_load_writeback (
        .clk, .rst, .load_push, .push_attr, .attr_full, .attr_empty,
        .local_valid, .pbus_valid, .local_data, .pbus_data,
        .wb_done, .wb_id, .wb_rd
    );

endmodule

`default_nettype wire

// File: test/lsu_assertions.sv
/* Writeback and peripheral bus protocol checks. Each bind ties off the
   inputs that the bound module does not have */
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions (
    input logic clk,
    input logic rst,
    input logic wb_done,
    input logic attr_empty,
    input logic pbus_req,
    input logic pbus_ack
);
    logic strobe_pending;

    // Set by the strobe, cleared by the ack
    always_ff @(posedge clk) begin
        if (rst)
            strobe_pending <= 1'b0;
        else
            strobe_pending <= (strobe_pending & ~pbus_ack) | pbus_req;
    end

    wb_needs_pending_load: assert property (@(posedge clk) disable iff (rst)
        wb_done |-> !attr_empty)
        else $error("wb_done with an empty attributes FIFO");

    single_strobe: assert property (@(posedge clk) disable iff (rst)
        pbus_req |-> !strobe_pending)
        else $error("pbus_req repeated before ack");

endmodule

bind load_writeback lsu_assertions i_wb_checks (
    .clk(clk), .rst(rst), .wb_done(wb_done), .attr_empty(attr_empty),
    .pbus_req(1'b0), .pbus_ack(1'b0)
);

bind pbus_sub_unit lsu_assertions i_pbus_checks (
    .clk(clk), .rst(rst), .wb_done(1'b0), .attr_empty(1'b1),
    .pbus_req(pbus_req), .pbus_ack(pbus_ack)
);

`default_nettype wire

// File: test/load_store_unit_tb.sv
/* Directed testbench for the load/store unit. Local memory starts undefined,
   so every test writes a word before it reads any part of it */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit_tb;
    import lsu_pkg::*;

    // About 50 accesses of at most 10 cycles each, with a wide margin
    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct packed {
        id_t   id;
        word_t data;
        int    cycle;
    } wb_entry_t;

    logic        clk = 1'b0;
    logic        rst;
    ls_request_t issue_req;
    logic        issue_new_request;
    logic        issue_ready;
    logic        exception_ack;
    logic        exception_valid;
    exc_code_t   exception_code;
    word_t       exception_tval;
    id_t         exception_id;
    logic        pbus_req;
    logic        pbus_we;
    word_t       pbus_addr;
    be_t         pbus_be;
    word_t       pbus_wdata;
    logic        pbus_ack;
    word_t       pbus_rdata;
    logic        wb_done;
    id_t         wb_id;
    word_t       wb_rd;
    logic        idle;

    integer      seed = 95162;
    int          cycles = 0;
    int          accept_cycle = 0;
    int          ack_count = 0;
    int          wb_count = 0;
    wb_entry_t   wb_q[$];
    word_t       ref_local [256];
    word_t       ref_pbus [256];
    word_t       pbus_mem [256];

    load_store_unit #(
        .LOCAL_MEM_WORDS(256),
        .ATTR_DEPTH(2)
    ) i_load_store_unit (.*);

    always #2 clk = ~clk;

    ////////////////////
    // Reporting and compares
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            fail_now($sformatf("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_id(input id_t got, input id_t exp, input string what);
        if (got !== exp)
            fail_now($sformatf("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_exc(input exc_code_t got, input exc_code_t exp, input string what);
        if (got !== exp)
            fail_now($sformatf("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    ////////////////////
    // Monitor, cycle count and timeout
    always @(posedge clk) begin
        if (issue_new_request && issue_ready)
            accept_cycle = cycles;
        if (wb_done) begin
            wb_q.push_back('{id: wb_id, data: wb_rd, cycle: cycles});
            wb_count++;
        end
        if (pbus_ack)
            ack_count++;
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            fail_now($sformatf("Timeout after %0d cycles, a test did not complete", cycles));
    end

    // Peripheral device that acks 1 to 4 cycles after the strobe
    always begin : pbus_device
        int delay;
        int idx;
        @(negedge clk);
        if (!rst && pbus_req) begin
            delay = ($random(seed) & 3) + 1;
            repeat (delay) @(negedge clk);
            idx = int'(pbus_addr[9:2]);
            if (pbus_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (pbus_be[b])
                        pbus_mem[idx][b*8 +: 8] = pbus_wdata[b*8 +: 8];
                end
            end
            pbus_rdata = pbus_mem[idx];
            pbus_ack = 1'b1;
            @(negedge clk);
            pbus_ack = 1'b0;
        end
    end

    ////////////////////
    // Reference memory model
    function automatic word_t fill_word(input int idx);
        return word_t'(idx) * 32'h9E37_79B9 ^ 32'hC001_0000;
    endfunction

    task automatic ref_write(input word_t addr, input fn3_t fn3, input word_t data);
        word_t w;
        w = addr[31] ? ref_pbus[addr[9:2]] : ref_local[addr[9:2]];
        case (fn3)
            FN3_B:   w[8 * int'(addr[1:0]) +: 8] = data[7:0];
            FN3_H:   w[16 * int'(addr[1]) +: 16] = data[15:0];
            default: w = data;
        endcase
        if (addr[31])
            ref_pbus[addr[9:2]] = w;
        else
            ref_local[addr[9:2]] = w;
    endtask

    function automatic word_t ref_load(input word_t addr, input fn3_t fn3);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = addr[31] ? ref_pbus[addr[9:2]] : ref_local[addr[9:2]];
        b = w[8 * int'(addr[1:0]) +: 8];
        h = w[16 * int'(addr[1]) +: 16];
        case (fn3)
            FN3_B:   return {{24{b[7]}}, b};
            FN3_BU:  return {24'h0, b};
            FN3_H:   return {{16{h[15]}}, h};
            FN3_HU:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    ////////////////////
    // Issue helpers
    task automatic send(input word_t rs1, input logic [11:0] offset, input word_t rs2,
                        input fn3_t fn3, input logic load, input id_t id);
        issue_req = '{rs1: rs1, offset: offset, rs2: rs2, fn3: fn3,
                      load: load, store: ~load, id: id};
        @(negedge clk);
        while (!issue_ready)
            @(negedge clk);
        issue_new_request = 1'b1;
        @(negedge clk);
        issue_new_request = 1'b0;
    endtask

    task automatic wait_pbus_ack();
        int target;
        target = ack_count + 1;
        while (ack_count < target) begin
            if (issue_ready !== 1'b0)
                fail_now("issue_ready high while a peripheral access is outstanding");
            @(negedge clk);
        end
    endtask

    task automatic wait_result(output wb_entry_t e);
        while (wb_q.size() == 0)
            @(negedge clk);
        e = wb_q.pop_front();
    endtask

    // Negative offset keeps the offset sign extension in every access
    task automatic store(input word_t addr, input fn3_t fn3, input word_t data, input id_t id);
        send(addr + 32'd20, 12'hFEC, data, fn3, 1'b0, id);
        ref_write(addr, fn3, data);
        if (addr[31])
            wait_pbus_ack();
    endtask

    task automatic load_check(input word_t addr, input fn3_t fn3, input id_t id);
        wb_entry_t e;
        send(addr + 32'd20, 12'hFEC, '0, fn3, 1'b1, id);
        if (addr[31])
            wait_pbus_ack();
        wait_result(e);
        check_id(e.id, id, "wb_id");
        check_word(e.data, ref_load(addr, fn3), "wb_rd");
        if (!addr[31] && e.cycle != accept_cycle + 1)
            fail_now("Local load result did not arrive one cycle after accept");
    endtask

    task automatic expect_exception(input exc_code_t code, input word_t tval, input id_t id);
        if (exception_valid !== 1'b1)
            fail_now("exception_valid did not rise after a misaligned request");
        check_exc(exception_code, code, "exception_code");
        check_word(exception_tval, tval, "exception_tval");
        check_id(exception_id, id, "exception_id");
        // An aligned local load is still blocked while the exception is pending
        issue_req = '{rs1: 32'h0, offset: 12'h0, rs2: 32'h0, fn3: FN3_W,
                      load: 1'b1, store: 1'b0, id: id};
        repeat (3) begin
            @(negedge clk);
            if (issue_ready !== 1'b0 || exception_valid !== 1'b1)
                fail_now("issue_ready rose or the exception dropped before ack");
        end
        exception_ack = 1'b1;
        @(negedge clk);
        exception_ack = 1'b0;
        if (exception_valid !== 1'b0 || issue_ready !== 1'b1)
            fail_now("Exception not cleared by ack");
    endtask

    ////////////////////
    // Directed tests
    task automatic test_reset_state();
        if (exception_valid !== 1'b0 || wb_done !== 1'b0 || pbus_req !== 1'b0)
            fail_now("Outputs not cleared after reset");
        if (issue_ready !== 1'b1 || idle !== 1'b1)
            fail_now("Unit not ready and idle after reset");
    endtask

    task automatic test_local_word();
        send(32'h0000_0050, 12'hFF0, 32'hDEAD_BEEF, FN3_W, 1'b0, 4'd1);
        ref_write(32'h0000_0040, FN3_W, 32'hDEAD_BEEF);
        load_check(32'h0000_0040, FN3_W, 4'd3);
        store(32'h0000_03FC, FN3_W, 32'h0123_4567, 4'd4);
        load_check(32'h0000_03FC, FN3_W, 4'd5);
    endtask

    task automatic test_narrow_local();
        word_t a;
        store(32'h0000_0100, FN3_W, 32'h1234_5678, 4'd2);
        // Upper rs2 bits must not leak into other lanes
        for (int i = 0; i < 4; i++) begin
            a = 32'h0000_0100 + word_t'(i);
            store(a, FN3_B, {24'hABCDEF, 8'h5A ^ 8'(i * 'h4C)}, 4'd2);
        end
        for (int i = 0; i < 4; i++) begin
            a = 32'h0000_0100 + word_t'(i);
            load_check(a, FN3_B, 4'd9);
            load_check(a, FN3_BU, 4'd10);
        end
        store(32'h0000_0100, FN3_H, 32'hFFFF_F00D, 4'd2);
        store(32'h0000_0102, FN3_H, 32'h8888_4321, 4'd2);
        for (int i = 0; i < 4; i += 2) begin
            a = 32'h0000_0100 + word_t'(i);
            load_check(a, FN3_H, 4'd11);
            load_check(a, FN3_HU, 4'd12);
        end
        load_check(32'h0000_0103, FN3_B, 4'd13);
        load_check(32'h0000_0100, FN3_W, 4'd14);
    endtask

    task automatic test_pbus();
        store(32'h8000_0020, FN3_W, 32'hCAFE_F00D, 4'd6);
        store(32'h8000_0021, FN3_B, 32'h0000_009C, 4'd6);
        store(32'h8000_0022, FN3_H, 32'h0000_8421, 4'd6);
        load_check(32'h8000_0020, FN3_W, 4'hA);
        load_check(32'h8000_0021, FN3_B, 4'hB);
        load_check(32'h8000_0021, FN3_BU, 4'hC);
        load_check(32'h8000_0022, FN3_H, 4'hD);
        load_check(32'h8000_0022, FN3_HU, 4'hE);
        load_check(32'h8000_0020, FN3_H, 4'hF);
        load_check(32'h8000_0044, FN3_W, 4'h1);
        for (int i = 0; i < 256; i++)
            check_word(pbus_mem[i], ref_pbus[i], "peripheral memory word");
    endtask

    task automatic test_misaligned();
        int count;
        store(32'h0000_0080, FN3_W, 32'hA1B2_C3D4, 4'd3);
        count = wb_count;
        send(32'h0000_0041, 12'h000, 32'h0, FN3_H, 1'b1, 4'd5);
        expect_exception(EXC_LOAD_MISALIGNED, 32'h0000_0041, 4'd5);
        send(32'h0000_0080, 12'h002, 32'h0BAD_0BAD, FN3_W, 1'b0, 4'd6);
        expect_exception(EXC_STORE_MISALIGNED, 32'h0000_0082, 4'd6);
        if (wb_count != count)
            fail_now("A misaligned access produced a writeback");
        load_check(32'h0000_0080, FN3_W, 4'd7);
    endtask

    task automatic test_alternate();
        wb_entry_t e;
        wb_entry_t exp_q[$];
        word_t     a;
        fn3_t      fn3;
        store(32'h0000_0200, FN3_W, 32'h0F1E_2D3C, 4'd1);
        store(32'h8000_0100, FN3_W, 32'h7766_D544, 4'd2);
        for (int i = 0; i < 6; i++) begin
            a = ((i % 2 == 0) ? 32'h0000_0200 : 32'h8000_0100) + word_t'(i / 2);
            fn3 = (i < 3) ? FN3_B : FN3_BU;
            exp_q.push_back('{id: id_t'(i + 8), data: ref_load(a, fn3), cycle: 0});
            send(a + 32'd20, 12'hFEC, '0, fn3, 1'b1, id_t'(i + 8));
        end
        foreach (exp_q[i]) begin
            wait_result(e);
            check_id(e.id, exp_q[i].id, "wb_id in issue order");
            check_word(e.data, exp_q[i].data, "wb_rd in issue order");
        end
        if (idle !== 1'b1)
            fail_now("idle low after all loads completed");
    endtask

    initial begin
        rst = 1'b1;
        issue_req = '0;
        issue_new_request = 1'b0;
        exception_ack = 1'b0;
        pbus_ack = 1'b0;
        pbus_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            ref_local[i] = '0;
            ref_pbus[i] = fill_word(i);
            pbus_mem[i] = fill_word(i);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset_state();
        test_local_word();
        test_narrow_local();
        test_pbus();
        test_misaligned();
        test_alternate();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/lsu_pkg.sv
rtl/ls_issue.sv
rtl/local_mem_sub_unit.sv
rtl/pbus_sub_unit.sv
rtl/load_writeback.sv
rtl/load_store_unit.sv
test/lsu_assertions.sv
test/load_store_unit_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := load_store_unit_tb
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

# Verdict comes from the log, since tee hides the simulator's exit status
run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@grep -q "Test OK" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
